//--- ldst_subsystem.f
src/pkg_ldst_isa.sv
src/pkg_ldst_access.sv
src/ldst_channel.sv
src/ldst_unit.sv
src/stride_access_engine.sv
src/local_mem.sv
src/ldst_subsystem.sv
test/ldst_subsystem_assert.sv
test/tb_ldst_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the load/store subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ldst_subsystem.f \
	--top-module tb_ldst_subsystem -o sim_ldst_subsystem \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_ldst_subsystem +verilator+error+limit+100000 > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

//--- src/ldst_channel.sv
// Load/store descriptor queue

`timescale 1ns/10ps

module ldst_channel #(
	parameter int DEPTH_BUFF_LDST	= 4
)(
	input	logic									clock,
	input	logic									rst_n,
	input	logic									push,			// Enqueue descriptor
	input	logic [pkg_ldst_isa::ISSUE_W-1:0]		push_issue_no,
	input	logic [pkg_ldst_access::LEN_W-1:0]		push_length,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		push_stride,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		push_base,
	input	logic [pkg_ldst_access::DATA_W-1:0]		push_data,		// Store word
	output	logic									full,
	input	logic									pop,			// Drop head entry
	output	logic									head_valid,
	output	logic [pkg_ldst_isa::ISSUE_W-1:0]		head_issue_no,
	output	logic [pkg_ldst_access::LEN_W-1:0]		head_length,
	output	logic [pkg_ldst_access::ADDR_W-1:0]		head_stride,
	output	logic [pkg_ldst_access::ADDR_W-1:0]		head_base,
	output	logic [pkg_ldst_access::DATA_W-1:0]		head_data
);

	localparam int PTR_W	= (DEPTH_BUFF_LDST > 1) ? $clog2(DEPTH_BUFF_LDST) : 1;
	localparam int CNT_W	= $clog2(DEPTH_BUFF_LDST + 1);

	logic [pkg_ldst_isa::ISSUE_W-1:0]		buf_issue_no	[DEPTH_BUFF_LDST];
	logic [pkg_ldst_access::LEN_W-1:0]		buf_length		[DEPTH_BUFF_LDST];
	logic [pkg_ldst_access::ADDR_W-1:0]		buf_stride		[DEPTH_BUFF_LDST];
	logic [pkg_ldst_access::ADDR_W-1:0]		buf_base		[DEPTH_BUFF_LDST];
	logic [pkg_ldst_access::DATA_W-1:0]		buf_data		[DEPTH_BUFF_LDST];

	logic [PTR_W-1:0]						wr_ptr;
	logic [PTR_W-1:0]						rd_ptr;
	logic [CNT_W-1:0]						count;

	logic									do_push;
	logic									do_pop;

	assign full				= count == CNT_W'(DEPTH_BUFF_LDST);
	assign head_valid		= count != '0;

	assign do_push			= push & ~full;
	assign do_pop			= pop & head_valid;

	// Oldest entry sits at rd_ptr
	assign head_issue_no	= buf_issue_no[rd_ptr];
	assign head_length		= buf_length[rd_ptr];
	assign head_stride		= buf_stride[rd_ptr];
	assign head_base		= buf_base[rd_ptr];
	assign head_data		= buf_data[rd_ptr];

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end
		else begin
			if (do_push) begin
				if (wr_ptr == PTR_W'(DEPTH_BUFF_LDST - 1))	// Circular wrap
					wr_ptr	<= '0;
				else
					wr_ptr	<= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (rd_ptr == PTR_W'(DEPTH_BUFF_LDST - 1))
					rd_ptr	<= '0;
				else
					rd_ptr	<= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop)
				count	<= count + 1'b1;
			else if (!do_push && do_pop)
				count	<= count - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Descriptor storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			buf_issue_no[wr_ptr]	<= push_issue_no;
			buf_length[wr_ptr]		<= push_length;
			buf_stride[wr_ptr]		<= push_stride;
			buf_base[wr_ptr]		<= push_base;
			buf_data[wr_ptr]		<= push_data;
		end
	end

endmodule

//--- src/ldst_subsystem.sv
// Load/store subsystem top level

`timescale 1ns/10ps

module ldst_subsystem #(
	parameter int DEPTH_BUFF_LDST	= 4,
	parameter int DEPTH_LD_DATA		= 4
)(
	input	logic									clock,
	input	logic									rst_n,
	input	logic									cmd_req,
	input	pkg_ldst_isa::ldst_op_t					cmd_op,
	input	logic [pkg_ldst_access::LEN_W-1:0]		cmd_length,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		cmd_stride,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		cmd_base,
	input	logic [pkg_ldst_access::DATA_W-1:0]		cmd_data,
	output	logic									cmd_ack,
	output	logic									wb_valid,
	output	logic [pkg_ldst_access::DATA_W-1:0]		wb_data,
	input	logic									wb_ready,
	output	logic									done,
	output	logic [pkg_ldst_isa::ISSUE_W-1:0]		done_issue_no,
	output	logic									done_store
);

	logic									ld_push, st_push, ld_pop, st_pop;
	logic									ld_full, st_full;
	logic									ld_head_valid, st_head_valid;
	logic [pkg_ldst_isa::ISSUE_W-1:0]		push_issue_no, ld_head_issue_no, st_head_issue_no;
	logic [pkg_ldst_access::LEN_W-1:0]		push_length, ld_head_length, st_head_length;
	logic [pkg_ldst_access::ADDR_W-1:0]		push_stride, ld_head_stride, st_head_stride;
	logic [pkg_ldst_access::ADDR_W-1:0]		push_base, ld_head_base, st_head_base;
	logic [pkg_ldst_access::DATA_W-1:0]		push_data, ld_head_data, st_head_data;

	logic									acc_req, acc_store, acc_ack;
	logic [pkg_ldst_access::LEN_W-1:0]		acc_length;
	logic [pkg_ldst_access::ADDR_W-1:0]		acc_stride, acc_base;
	logic [pkg_ldst_access::DATA_W-1:0]		acc_data;

	logic									mem_en, mem_we;
	logic [pkg_ldst_access::ADDR_W-1:0]		mem_addr;
	logic [pkg_ldst_access::DATA_W-1:0]		mem_wdata, mem_rdata;

	ldst_unit #(
		.DEPTH_BUFF_LDST(	DEPTH_BUFF_LDST		)
	) ldst_unit_inst (
		.clock, .rst_n,
		.cmd_req, .cmd_op, .cmd_length, .cmd_stride, .cmd_base, .cmd_data, .cmd_ack,
		.ld_push, .st_push, .push_issue_no, .push_length, .push_stride,
		.push_base, .push_data, .ld_pop, .st_pop, .ld_full, .st_full,
		.ld_head_valid, .st_head_valid, .ld_head_issue_no, .st_head_issue_no,
		.ld_head_length, .st_head_length, .ld_head_stride, .st_head_stride,
		.ld_head_base, .st_head_base, .ld_head_data, .st_head_data,
		.acc_req, .acc_store, .acc_length, .acc_stride, .acc_base, .acc_data, .acc_ack,
		.done, .done_issue_no, .done_store
	);

	ldst_channel #(
		.DEPTH_BUFF_LDST(	DEPTH_BUFF_LDST		)
	) ld_channel (
		.clock, .rst_n,
		.push(			ld_push				),
		.push_issue_no, .push_length, .push_stride, .push_base, .push_data,
		.full(			ld_full				),
		.pop(			ld_pop				),
		.head_valid(	ld_head_valid		),
		.head_issue_no(	ld_head_issue_no	),
		.head_length(	ld_head_length		),
		.head_stride(	ld_head_stride		),
		.head_base(		ld_head_base		),
		.head_data(		ld_head_data		)
	);

	ldst_channel #(
		.DEPTH_BUFF_LDST(	DEPTH_BUFF_LDST		)
	) st_channel (
		.clock, .rst_n,
		.push(			st_push				),
		.push_issue_no, .push_length, .push_stride, .push_base, .push_data,
		.full(			st_full				),
		.pop(			st_pop				),
		.head_valid(	st_head_valid		),
		.head_issue_no(	st_head_issue_no	),
		.head_length(	st_head_length		),
		.head_stride(	st_head_stride		),
		.head_base(		st_head_base		),
		.head_data(		st_head_data		)
	);

	stride_access_engine #(
		.DEPTH_LD_DATA(		DEPTH_LD_DATA		)
	) stride_access_engine_inst (
		.clock, .rst_n,
		.acc_req, .acc_store, .acc_length, .acc_stride, .acc_base, .acc_data, .acc_ack,
		.mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata,
		.wb_valid, .wb_data, .wb_ready
	);

	local_mem local_mem_inst (
		.clock, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
	);

endmodule

//--- src/ldst_unit.sv
// Load/store command intake and ordering

`timescale 1ns/10ps

module ldst_unit #(
	parameter int DEPTH_BUFF_LDST	= 4
)(
	input	logic									clock,
	input	logic									rst_n,
	input	logic									cmd_req,		// Four-phase request
	input	pkg_ldst_isa::ldst_op_t					cmd_op,
	input	logic [pkg_ldst_access::LEN_W-1:0]		cmd_length,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		cmd_stride,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		cmd_base,
	input	logic [pkg_ldst_access::DATA_W-1:0]		cmd_data,
	output	logic									cmd_ack,
	output	logic									ld_push,
	output	logic									st_push,
	output	logic [pkg_ldst_isa::ISSUE_W-1:0]		push_issue_no,
	output	logic [pkg_ldst_access::LEN_W-1:0]		push_length,
	output	logic [pkg_ldst_access::ADDR_W-1:0]		push_stride,
	output	logic [pkg_ldst_access::ADDR_W-1:0]		push_base,
	output	logic [pkg_ldst_access::DATA_W-1:0]		push_data,
	output	logic									ld_pop,
	output	logic									st_pop,
	input	logic									ld_full,
	input	logic									st_full,
	input	logic									ld_head_valid,
	input	logic									st_head_valid,
	input	logic [pkg_ldst_isa::ISSUE_W-1:0]		ld_head_issue_no,
	input	logic [pkg_ldst_isa::ISSUE_W-1:0]		st_head_issue_no,
	input	logic [pkg_ldst_access::LEN_W-1:0]		ld_head_length,
	input	logic [pkg_ldst_access::LEN_W-1:0]		st_head_length,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		ld_head_stride,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		st_head_stride,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		ld_head_base,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		st_head_base,
	input	logic [pkg_ldst_access::DATA_W-1:0]		ld_head_data,
	input	logic [pkg_ldst_access::DATA_W-1:0]		st_head_data,
	output	logic									acc_req,		// To access engine
	output	logic									acc_store,
	output	logic [pkg_ldst_access::LEN_W-1:0]		acc_length,
	output	logic [pkg_ldst_access::ADDR_W-1:0]		acc_stride,
	output	logic [pkg_ldst_access::ADDR_W-1:0]		acc_base,
	output	logic [pkg_ldst_access::DATA_W-1:0]		acc_data,
	input	logic									acc_ack,
	output	logic									done,			// One-cycle completion
	output	logic [pkg_ldst_isa::ISSUE_W-1:0]		done_issue_no,
	output	logic									done_store
);

	// Both queues plus the active access must fit in one issue-number lap
	if (2 * DEPTH_BUFF_LDST >= (1 << pkg_ldst_isa::ISSUE_W)) begin : g_depth_check
		$error("Descriptor queues too deep for the issue number width");
	end

	logic [pkg_ldst_isa::ISSUE_W-1:0]		issue_no;		// Next number to hand out
	logic [pkg_ldst_isa::ISSUE_W-1:0]		acc_issue_no;
	logic [pkg_ldst_isa::ISSUE_W-1:0]		ld_age;
	logic [pkg_ldst_isa::ISSUE_W-1:0]		st_age;
	logic									tgt_full;
	logic									cmd_accept;
	logic									pick_st;
	logic									acc_launch;
	logic									acc_finish;

	////////////////////////////////////////////////////////////
	// Command intake
	////////////////////////////////////////////////////////////

	always_comb begin
		case (cmd_op)
			pkg_ldst_isa::OP_LOAD:	tgt_full = ld_full;
			pkg_ldst_isa::OP_STORE:	tgt_full = st_full;
			default:				tgt_full = 1'b0;	// NOP never blocks
		endcase
	end

	assign cmd_accept		= cmd_req & ~cmd_ack & ~tgt_full;
	assign ld_push			= cmd_accept & (cmd_op == pkg_ldst_isa::OP_LOAD);
	assign st_push			= cmd_accept & (cmd_op == pkg_ldst_isa::OP_STORE);

	assign push_issue_no	= issue_no;
	assign push_length		= cmd_length;
	assign push_stride		= cmd_stride;
	assign push_base		= cmd_base;
	assign push_data		= cmd_data;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cmd_ack		<= 1'b0;
			issue_no	<= '0;
		end
		else begin
			if (cmd_accept)
				cmd_ack		<= 1'b1;
			else if (cmd_ack && !cmd_req)
				cmd_ack		<= 1'b0;
			if (ld_push || st_push)
				issue_no	<= issue_no + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Age selection and access request
	////////////////////////////////////////////////////////////

	// Larger distance from the next issue number means older
	assign ld_age		= issue_no - ld_head_issue_no;
	assign st_age		= issue_no - st_head_issue_no;
	assign pick_st		= st_head_valid & (~ld_head_valid | (st_age > ld_age));

	assign acc_launch	= ~acc_req & ~acc_ack & (ld_head_valid | st_head_valid);
	assign acc_finish	= acc_req & acc_ack;

	assign ld_pop		= acc_finish & ~acc_store;
	assign st_pop		= acc_finish & acc_store;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			acc_req		<= 1'b0;
			acc_store	<= 1'b0;
		end
		else if (acc_finish) begin
			acc_req		<= 1'b0;
		end
		else if (acc_launch) begin
			acc_req		<= 1'b1;
			acc_store	<= pick_st;
		end
	end

	// Descriptor held stable while acc_req is high
	always_ff @(posedge clock) begin
		if (acc_launch) begin
			acc_issue_no	<= pick_st ? st_head_issue_no : ld_head_issue_no;
			acc_length		<= pick_st ? st_head_length : ld_head_length;
			acc_stride		<= pick_st ? st_head_stride : ld_head_stride;
			acc_base		<= pick_st ? st_head_base : ld_head_base;
			acc_data		<= pick_st ? st_head_data : ld_head_data;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			done			<= 1'b0;
			done_issue_no	<= '0;
			done_store		<= 1'b0;
		end
		else begin
			done			<= acc_finish;
			if (acc_finish) begin
				done_issue_no	<= acc_issue_no;
				done_store		<= acc_store;
			end
		end
	end

endmodule

//--- src/local_mem.sv
// Scratch memory, one synchronous port

`timescale 1ns/10ps

module local_mem (
	input	logic									clock,
	input	logic									mem_en,
	input	logic									mem_we,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		mem_addr,
	input	logic [pkg_ldst_access::DATA_W-1:0]		mem_wdata,
	output	logic [pkg_ldst_access::DATA_W-1:0]		mem_rdata		// Valid one cycle after read
);

	logic [pkg_ldst_access::DATA_W-1:0]		mem_array	[1 << pkg_ldst_access::ADDR_W];

	always_ff @(posedge clock) begin
		if (mem_en) begin
			if (mem_we)
				mem_array[mem_addr]	<= mem_wdata;
			else
				mem_rdata			<= mem_array[mem_addr];	// Registered read
		end
	end

endmodule

//--- src/pkg_ldst_access.sv
// Access path widths and engine states

package pkg_ldst_access;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int DATA_W		= 32;		// Data word
	localparam int ADDR_W		= 8;		// 256-word scratch memory
	localparam int LEN_W		= 4;		// 0 to 15 elements

	////////////////////////////////////////////////////////////
	// Strided access engine
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ACC_IDLE	= 2'd0,			// Waiting for acc_req
		ACC_WALK	= 2'd1,			// One element per cycle
		ACC_FLUSH	= 2'd2,			// Last read returning
		ACC_ACK		= 2'd3			// Hold acc_ack until req drops
	} access_state_t;

endpackage

//--- src/pkg_ldst_isa.sv
// Load/store command encoding

package pkg_ldst_isa;

	////////////////////////////////////////////////////////////
	// Issue numbering
	////////////////////////////////////////////////////////////

	// Wraps at 16, so ages are taken modulo 16
	localparam int ISSUE_W		= 4;

	////////////////////////////////////////////////////////////
	// Command opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_NOP		= 2'd0,			// Acknowledged, no access
		OP_LOAD		= 2'd1,			// Strided read to write-back
		OP_STORE	= 2'd2			// Strided fill with one word
	} ldst_op_t;

endpackage

//--- src/stride_access_engine.sv
// Strided memory access engine

`timescale 1ns/10ps

module stride_access_engine #(
	parameter int DEPTH_LD_DATA		= 4
)(
	input	logic									clock,
	input	logic									rst_n,
	input	logic									acc_req,
	input	logic									acc_store,		// 1 store, 0 load
	input	logic [pkg_ldst_access::LEN_W-1:0]		acc_length,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		acc_stride,
	input	logic [pkg_ldst_access::ADDR_W-1:0]		acc_base,
	input	logic [pkg_ldst_access::DATA_W-1:0]		acc_data,
	output	logic									acc_ack,
	output	logic									mem_en,
	output	logic									mem_we,
	output	logic [pkg_ldst_access::ADDR_W-1:0]		mem_addr,
	output	logic [pkg_ldst_access::DATA_W-1:0]		mem_wdata,
	input	logic [pkg_ldst_access::DATA_W-1:0]		mem_rdata,
	output	logic									wb_valid,
	output	logic [pkg_ldst_access::DATA_W-1:0]		wb_data,
	input	logic									wb_ready
);

	localparam int PTR_W	= (DEPTH_LD_DATA > 1) ? $clog2(DEPTH_LD_DATA) : 1;
	localparam int CNT_W	= $clog2(DEPTH_LD_DATA + 1);

	pkg_ldst_access::access_state_t			state;
	logic [pkg_ldst_access::LEN_W-1:0]		elem_cnt;
	logic [pkg_ldst_access::ADDR_W-1:0]		cur_addr;		// base + i*stride
	logic									rd_pend;		// Read in flight
	logic									last_elem;
	logic									can_issue;
	logic									step;

	logic [pkg_ldst_access::DATA_W-1:0]		q_mem	[DEPTH_LD_DATA];
	logic [PTR_W-1:0]						q_wr_ptr;
	logic [PTR_W-1:0]						q_rd_ptr;
	logic [CNT_W-1:0]						q_count;
	logic [CNT_W:0]							q_used;
	logic									q_pop;

	////////////////////////////////////////////////////////////
	// Address walk
	////////////////////////////////////////////////////////////

	// Held words plus the read still in flight
	assign q_used		= {1'b0, q_count} + {{CNT_W{1'b0}}, rd_pend};
	assign can_issue	= q_used < (CNT_W + 1)'(DEPTH_LD_DATA);
	assign step			= acc_store | can_issue;
	assign last_elem	= elem_cnt == (acc_length - 1'b1);

	assign mem_en		= (state == pkg_ldst_access::ACC_WALK) & step;
	assign mem_we		= acc_store;
	assign mem_addr		= cur_addr;
	assign mem_wdata	= acc_data;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state		<= pkg_ldst_access::ACC_IDLE;
			acc_ack		<= 1'b0;
			elem_cnt	<= '0;
			cur_addr	<= '0;
		end
		else begin
			case (state)
				pkg_ldst_access::ACC_IDLE: begin
					if (acc_req) begin
						elem_cnt	<= '0;
						cur_addr	<= acc_base;
						if (acc_length == '0)				// Nothing to touch
							state	<= pkg_ldst_access::ACC_ACK;
						else
							state	<= pkg_ldst_access::ACC_WALK;
					end
				end
				pkg_ldst_access::ACC_WALK: begin
					if (step) begin
						cur_addr	<= cur_addr + acc_stride;	// Wraps mod 256
						elem_cnt	<= elem_cnt + 1'b1;
						if (last_elem)
							state	<= pkg_ldst_access::ACC_FLUSH;
					end
				end
				pkg_ldst_access::ACC_FLUSH: begin
					state	<= pkg_ldst_access::ACC_ACK;
				end
				default: begin
					if (!acc_ack)
						acc_ack	<= 1'b1;
					else if (!acc_req) begin
						acc_ack	<= 1'b0;
						state	<= pkg_ldst_access::ACC_IDLE;
					end
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Load return queue
	////////////////////////////////////////////////////////////

	assign wb_valid		= q_count != '0;
	assign wb_data		= q_mem[q_rd_ptr];
	assign q_pop		= wb_valid & wb_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_pend		<= 1'b0;
			q_wr_ptr	<= '0;
			q_rd_ptr	<= '0;
			q_count		<= '0;
		end
		else begin
			rd_pend		<= mem_en & ~mem_we;
			if (rd_pend)
				q_wr_ptr	<= (q_wr_ptr == PTR_W'(DEPTH_LD_DATA - 1)) ? '0 : q_wr_ptr + 1'b1;
			if (q_pop)
				q_rd_ptr	<= (q_rd_ptr == PTR_W'(DEPTH_LD_DATA - 1)) ? '0 : q_rd_ptr + 1'b1;
			if (rd_pend && !q_pop)
				q_count		<= q_count + 1'b1;
			else if (!rd_pend && q_pop)
				q_count		<= q_count - 1'b1;
		end
	end

	// Returning word lands one cycle after its read
	always_ff @(posedge clock) begin
		if (rd_pend)
			q_mem[q_wr_ptr]	<= mem_rdata;
	end

endmodule

//--- test/ldst_subsystem_assert.sv
// Load/store subsystem assertions

`timescale 1ns/10ps

module ldst_subsystem_assert (
	input	logic									clock,
	input	logic									rst_n,
	input	logic									cmd_req,
	input	pkg_ldst_isa::ldst_op_t					cmd_op,
	input	logic									cmd_ack,
	input	logic									ld_full,
	input	logic									st_full,
	input	logic									acc_req,
	input	logic									acc_ack,
	input	logic									mem_en,
	input	logic									wb_valid,
	input	logic									wb_ready,
	input	logic [pkg_ldst_access::DATA_W-1:0]		wb_data,
	input	logic									done,
	input	logic [pkg_ldst_isa::ISSUE_W-1:0]		done_issue_no
);

	int										fail_count = 0;		// Read by the testbench
	logic [pkg_ldst_isa::ISSUE_W-1:0]		next_done_no;		// Issue order of completions

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			next_done_no	<= '0;
		else if (done)
			next_done_no	<= next_done_no + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Reset
	////////////////////////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clock)
		(!rst_n ##1 !rst_n) |-> !cmd_ack && !wb_valid && !done)
		else begin
			fail_count++;
			$error("Outputs active during reset");
		end

	a_reset_release: assert property (@(posedge clock)
		$rose(rst_n) |=> !cmd_ack && !wb_valid && !done)
		else begin
			fail_count++;
			$error("Outputs active in the first cycle after reset");
		end

	////////////////////////////////////////////////////////////
	// Command intake
	////////////////////////////////////////////////////////////

	a_ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
		!cmd_req |=> !$rose(cmd_ack))
		else begin
			fail_count++;
			$error("cmd_ack rose without cmd_req");
		end

	a_ack_hold: assert property (@(posedge clock) disable iff (!rst_n)
		cmd_ack && cmd_req |=> cmd_ack)
		else begin
			fail_count++;
			$error("cmd_ack dropped while cmd_req still high");
		end

	a_ack_release: assert property (@(posedge clock) disable iff (!rst_n)
		cmd_ack && !cmd_req |=> !cmd_ack)
		else begin
			fail_count++;
			$error("cmd_ack stayed high after cmd_req fell");
		end

	a_full_withhold: assert property (@(posedge clock) disable iff (!rst_n)
		cmd_req && !cmd_ack
		&& ((cmd_op == pkg_ldst_isa::OP_LOAD && ld_full)
		|| (cmd_op == pkg_ldst_isa::OP_STORE && st_full)) |=> !cmd_ack)
		else begin
			fail_count++;
			$error("Command acknowledged into a full channel");
		end

	////////////////////////////////////////////////////////////
	// Access path and write-back
	////////////////////////////////////////////////////////////

	a_acc_ack_req: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(acc_ack) |-> acc_req)
		else begin
			fail_count++;
			$error("Engine acknowledged with no access request");
		end

	a_mem_in_access: assert property (@(posedge clock) disable iff (!rst_n)
		mem_en |-> acc_req && !acc_ack)
		else begin
			fail_count++;
			$error("Memory accessed outside an active access");
		end

	a_wb_hold: assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid && !wb_ready |=> wb_valid && $stable(wb_data))
		else begin
			fail_count++;
			$error("Write-back word changed or vanished while stalled");
		end

	////////////////////////////////////////////////////////////
	// Completion
	////////////////////////////////////////////////////////////

	a_done_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		done |=> !done)
		else begin
			fail_count++;
			$error("done held longer than one cycle");
		end

	a_done_order: assert property (@(posedge clock) disable iff (!rst_n)
		done |-> done_issue_no == next_done_no)
		else begin
			fail_count++;
			$error("Completion out of issue order");
		end

endmodule

bind ldst_subsystem ldst_subsystem_assert ldst_subsystem_assert_inst (
	.clock, .rst_n, .cmd_req, .cmd_op, .cmd_ack, .ld_full, .st_full,
	.acc_req, .acc_ack, .mem_en,
	.wb_valid, .wb_ready, .wb_data, .done, .done_issue_no
);

//--- test/tb_ldst_subsystem.sv
// Load/store subsystem testbench

`timescale 1ns/10ps

module tb_ldst_subsystem;

	logic									clock = 1'b0;
	logic									rst_n;
	logic									cmd_req;
	pkg_ldst_isa::ldst_op_t					cmd_op;
	logic [pkg_ldst_access::LEN_W-1:0]		cmd_length;
	logic [pkg_ldst_access::ADDR_W-1:0]		cmd_stride;
	logic [pkg_ldst_access::ADDR_W-1:0]		cmd_base;
	logic [pkg_ldst_access::DATA_W-1:0]		cmd_data;
	logic									cmd_ack;
	logic									wb_valid;
	logic [pkg_ldst_access::DATA_W-1:0]		wb_data;
	logic									wb_ready = 1'b1;
	logic									done;
	logic [pkg_ldst_isa::ISSUE_W-1:0]		done_issue_no;
	logic									done_store;

	logic [31:0]		lfsr_state = 32'h4a4c2962;
	logic [31:0]		ready_lfsr = 32'h4a4c2962;	// Separate stream for wb_ready
	logic				ready_random = 1'b0;
	logic [31:0]		shadow		[256];			// Reference memory
	logic [31:0]		exp_words	[$];
	logic [4:0]			exp_done	[$];			// {store, issue number}
	logic [3:0]			next_issue = 4'd0;
	int					err_count = 0;
	int					cycles = 0;
	int					cycle_limit = 60;			// Reset and final drain

	ldst_subsystem #(
		.DEPTH_BUFF_LDST(	4	),
		.DEPTH_LD_DATA(		4	)
	) ldst_subsystem_inst (
		.clock, .rst_n, .cmd_req, .cmd_op, .cmd_length, .cmd_stride, .cmd_base,
		.cmd_data, .cmd_ack, .wb_valid, .wb_data, .wb_ready,
		.done, .done_issue_no, .done_store
	);

	always #50 clock = ~clock;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	always @(posedge clock) begin
		if (ready_random) begin
			ready_lfsr = lfsr_step(ready_lfsr);
			wb_ready <= ready_lfsr[0];					// Low about half the time
		end
		else
			wb_ready <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Command driver and reference model
	////////////////////////////////////////////////////////////

	task automatic send_cmd(input pkg_ldst_isa::ldst_op_t op, input logic [3:0] len,
			input logic [7:0] stride, input logic [7:0] base, input logic [31:0] data);
		logic [7:0] addr;
		cycle_limit += int'(len) + 40;
		@(posedge clock);
		cmd_req		<= 1'b1;
		cmd_op		<= op;
		cmd_length	<= len;
		cmd_stride	<= stride;
		cmd_base	<= base;
		cmd_data	<= data;
		do @(posedge clock); while (!cmd_ack);
		cmd_req		<= 1'b0;
		addr = base;
		for (int i = 0; i < int'(len); i++) begin		// Address walk modulo 256
			if (op == pkg_ldst_isa::OP_STORE)
				shadow[addr] = data;
			else if (op == pkg_ldst_isa::OP_LOAD)
				exp_words.push_back(shadow[addr]);
			addr = addr + stride;
		end
		if (op != pkg_ldst_isa::OP_NOP) begin
			exp_done.push_back({op == pkg_ldst_isa::OP_STORE, next_issue});
			next_issue = next_issue + 4'd1;
		end
		do @(posedge clock); while (cmd_ack);
	endtask

	////////////////////////////////////////////////////////////
	// Output monitors and watchdog
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		logic [31:0] exp_word;
		logic [4:0] exp_d;
		if (rst_n && wb_valid && wb_ready) begin
			if (exp_words.size() == 0) begin
				err_count++;
				$display("Write-back word arrived with no load word outstanding");
			end
			else begin
				exp_word = exp_words.pop_front();
				if (wb_data !== exp_word) begin
					err_count++;
					$display("[ERROR] wb_data expected %h observed %h", exp_word, wb_data);
				end
			end
		end
		if (rst_n && done) begin
			if (exp_done.size() == 0) begin
				err_count++;
				$display("done pulsed with no command outstanding");
			end
			else begin
				exp_d = exp_done.pop_front();
				if (done_issue_no !== exp_d[3:0] || done_store !== exp_d[4]) begin
					err_count++;
					$display("[ERROR] done_issue_no/done_store expected %h/%h observed %h/%h",
						exp_d[3:0], exp_d[4], done_issue_no, done_store);
				end
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		pkg_ldst_isa::ldst_op_t op;
		logic [1:0] sel;
		logic [3:0] len;
		logic [7:0] stride;
		logic [7:0] base;
		logic [31:0] data;
		int asrt_fails;
		rst_n		= 1'b0;
		cmd_req		= 1'b0;
		cmd_op		= pkg_ldst_isa::OP_NOP;
		cmd_length	= '0;
		cmd_stride	= '0;
		cmd_base	= '0;
		cmd_data	= '0;
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;
		repeat (2) @(posedge clock);

		for (int k = 0; k < 18; k++)					// Fill every word first
			send_cmd(pkg_ldst_isa::OP_STORE, 4'd15, 8'd1, 8'(k * 15), take_bits(32));

		for (int k = 0; k < 4; k++) begin				// Store then load back
			len = 4'(take_bits(4));
			stride = 8'(take_bits(8));
			base = 8'(take_bits(8));
			data = take_bits(32);
			send_cmd(pkg_ldst_isa::OP_STORE, len, stride, base, data);
			send_cmd(pkg_ldst_isa::OP_LOAD, len, stride, base, 32'd0);
		end

		for (int k = 0; k < 24; k++) begin				// Overlapping mix
			sel = 2'(take_bits(2));
			op = (sel == 2'd0) ? pkg_ldst_isa::OP_NOP
				: (sel[0] ? pkg_ldst_isa::OP_LOAD : pkg_ldst_isa::OP_STORE);
			len = 4'(take_bits(4));
			stride = 8'(take_bits(8));
			base = 8'(take_bits(8));
			data = take_bits(32);
			send_cmd(op, len, stride, base, data);
		end

		ready_random <= 1'b1;							// Write-back back-pressure
		for (int k = 0; k < 16; k++) begin
			op = (k % 4 == 3) ? pkg_ldst_isa::OP_STORE : pkg_ldst_isa::OP_LOAD;
			stride = 8'(take_bits(8));
			base = 8'(take_bits(8));
			data = take_bits(32);
			send_cmd(op, 4'd15, stride, base, data);
		end

		send_cmd(pkg_ldst_isa::OP_LOAD, 4'd0, 8'd3, 8'd40, 32'd0);
		send_cmd(pkg_ldst_isa::OP_STORE, 4'd0, 8'd5, 8'd90, 32'hdeadbeef);
		send_cmd(pkg_ldst_isa::OP_NOP, 4'd7, 8'd1, 8'd0, 32'd0);

		while (exp_words.size() != 0 || exp_done.size() != 0)
			@(posedge clock);
		repeat (10) @(posedge clock);					// Catch stray outputs

		asrt_fails = ldst_subsystem_inst.ldst_subsystem_assert_inst.fail_count;
		$display("Run complete: %0d testbench errors, %0d assertion failures",
			err_count, asrt_fails);
		if (err_count == 0 && asrt_fails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
